// ==== common/vWriteSettings_settings.svh ====
`ifndef VWRITE_SETTINGS_SVH
`define VWRITE_SETTINGS_SVH

// lanes in the cluster
`define VW_NUM_LANES 4

// buffer address, top bit picks the ping-pong half
`define VW_ADDR_W 10

// input word, buffer word and bus word share one width
`define VW_DATA_W 32

// period, duty and delay counters
`define VW_PERIOD_W 10

`define VW_LEN_W 8
`define VW_EXT_ADDR_W 32

`endif

// ==== common/vWritePkg.sv ====
`default_nettype none

`include "vWriteSettings_settings.svh"

package vWritePkg;

   // read side, buffer to databus
   typedef struct packed {
      logic [`VW_EXT_ADDR_W-1:0] extAddr;
      logic [`VW_PERIOD_W-1:0]   perA;
      logic [`VW_ADDR_W-1:0]     incrA;
      logic [`VW_LEN_W-1:0]      length;
   } readCfgT;

   // write side, input stream to buffer
   typedef struct packed {
      logic [`VW_ADDR_W-1:0]   iter;
      logic [`VW_PERIOD_W-1:0] per;
      logic [`VW_PERIOD_W-1:0] duty;
      logic [`VW_ADDR_W-1:0]   start;
      logic [`VW_ADDR_W-1:0]   shift;
      logic [`VW_ADDR_W-1:0]   incr;
      logic [`VW_PERIOD_W-1:0] delay;
      logic [`VW_ADDR_W-1:0]   iter2;
      logic [`VW_ADDR_W-1:0]   incr2;
      logic                    reverse;
   } writeCfgT;

   typedef struct packed {
      readCfgT  rd;
      writeCfgT wr;
      logic     pingPong;
   } laneCfgT;

   // one databus beat, strobe is always all ones
   typedef struct packed {
      logic [`VW_EXT_ADDR_W-1:0] addr;
      logic [`VW_DATA_W-1:0]     wdata;
      logic [`VW_LEN_W-1:0]      len;
   } busReqT;

endpackage

`default_nettype wire

// ==== hdl/addrGenNested.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vWriteSettings_settings.svh"

module addrGenNested (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    run,
   input  vWritePkg::writeCfgT     cfg,
   output logic [`VW_ADDR_W-1:0]   addr,
   output logic                    writeEn,
   output logic                    done
);

   logic                    busy;
   logic [`VW_PERIOD_W-1:0] delayCnt;
   logic [`VW_PERIOD_W-1:0] perCnt;
   logic [`VW_ADDR_W-1:0]   iterCnt;
   logic [`VW_ADDR_W-1:0]   outerCnt;
   logic [`VW_ADDR_W-1:0]   blockBase;
   logic [`VW_ADDR_W-1:0]   rowBase;
   logic [`VW_ADDR_W-1:0]   offset;
   logic                    active;

   assign active  = busy && (delayCnt == '0);
   assign writeEn = active && (perCnt < cfg.duty);
   assign addr    = rowBase + offset;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy      <= 1'b0;
         done      <= 1'b1;
         delayCnt  <= '0;
         perCnt    <= '0;
         iterCnt   <= '0;
         outerCnt  <= '0;
         blockBase <= '0;
         rowBase   <= '0;
         offset    <= '0;
      end else if (run) begin
         busy      <= 1'b1;
         done      <= 1'b0;
         delayCnt  <= cfg.delay;
         perCnt    <= '0;
         iterCnt   <= '0;
         outerCnt  <= '0;
         blockBase <= cfg.start;
         rowBase   <= cfg.start;
         offset    <= '0;
      end else if (busy && delayCnt != '0) begin
         delayCnt <= delayCnt - 1'b1;
      end else if (active) begin
         if (perCnt == cfg.per - 1'b1) begin
            perCnt <= '0;
            offset <= '0;
            if (iterCnt == cfg.iter - 1'b1) begin
               iterCnt <= '0;
               if (outerCnt == cfg.iter2 - 1'b1) begin
                  busy <= 1'b0;
                  done <= 1'b1;
               end else begin
                  // next outer block restarts the row base
                  outerCnt  <= outerCnt + 1'b1;
                  blockBase <= blockBase + cfg.incr2;
                  rowBase   <= blockBase + cfg.incr2;
               end
            end else begin
               iterCnt <= iterCnt + 1'b1;
               rowBase <= rowBase + cfg.shift;
            end
         end else begin
            perCnt <= perCnt + 1'b1;
            offset <= offset + cfg.incr;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/addrGenSimple.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vWriteSettings_settings.svh"

module addrGenSimple (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    run,
   input  logic [`VW_ADDR_W-1:0]   start,
   input  logic [`VW_ADDR_W-1:0]   incr,
   input  logic [`VW_PERIOD_W-1:0] period,
   input  logic [`VW_LEN_W-1:0]    count,
   output logic                    valid,
   input  logic                    ready,
   output logic [`VW_ADDR_W-1:0]   addr
);

   logic                    busy;
   logic [`VW_LEN_W-1:0]    remaining;
   logic [`VW_PERIOD_W-1:0] waitCnt;

   assign valid = busy && (waitCnt == '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy      <= 1'b0;
         remaining <= '0;
         waitCnt   <= '0;
         addr      <= '0;
      end else if (run) begin
         busy      <= (count != '0);
         remaining <= count;
         waitCnt   <= '0;
         addr      <= start;
      end else if (valid && ready) begin
         addr      <= addr + incr;
         remaining <= remaining - 1'b1;
         if (remaining == 1'b1)
            busy <= 1'b0;
         // period of 0 or 1 means back to back
         waitCnt <= (period > 1'b1) ? period - 1'b1 : '0;
      end else if (waitCnt != '0) begin
         waitCnt <= waitCnt - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/bufferMem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vWriteSettings_settings.svh"

module bufferMem (
   input  logic                  clk,
   input  logic                  writeEn,
   input  logic [`VW_ADDR_W-1:0] writeAddr,
   input  logic [`VW_DATA_W-1:0] writeData,
   input  logic                  readEn,
   input  logic [`VW_ADDR_W-1:0] readAddr,
   output logic [`VW_DATA_W-1:0] readData
);

   logic [`VW_DATA_W-1:0] mem [2**`VW_ADDR_W];

   always_ff @(posedge clk) begin
      if (writeEn)
         mem[writeAddr] <= writeData;
   end

   // one cycle read latency
   always_ff @(posedge clk) begin
      if (readEn)
         readData <= mem[readAddr];
   end

endmodule

`default_nettype wire

// ==== hdl/memReader.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vWriteSettings_settings.svh"

module memReader (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  sValid,
   output logic                  sReady,
   input  logic [`VW_ADDR_W-1:0] sAddr,
   output logic                  mValid,
   input  logic                  mReady,
   output logic [`VW_DATA_W-1:0] mData,
   output logic                  memEn,
   output logic [`VW_ADDR_W-1:0] memAddr,
   input  logic [`VW_DATA_W-1:0] memData
);

   logic [`VW_DATA_W-1:0] skid [2];
   logic                  wrPtr;
   logic                  rdPtr;
   logic [1:0]            count;
   logic                  rdPending;
   logic                  pop;
   logic [1:0]            held;

   assign pop    = mValid && mReady;
   // words held next cycle, before any new read lands
   assign held   = count + rdPending - pop;
   assign sReady = (held < 2'd2);
   assign memEn  = sValid && sReady;
   assign memAddr = sAddr;
   assign mValid = (count != '0);
   assign mData  = skid[rdPtr];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count     <= '0;
         rdPending <= 1'b0;
         wrPtr     <= 1'b0;
         rdPtr     <= 1'b0;
      end else begin
         count     <= held;
         rdPending <= memEn;
         if (rdPending)
            wrPtr <= ~wrPtr;
         if (pop)
            rdPtr <= ~rdPtr;
      end
   end

   always_ff @(posedge clk) begin
      if (rdPending)
         skid[wrPtr] <= memData;
   end

endmodule

`default_nettype wire

// ==== vWriteLane/vWriteLane.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vWriteSettings_settings.svh"

module vWriteLane (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,
   input  vWritePkg::laneCfgT    cfg,
   input  logic [`VW_DATA_W-1:0] inData,
   output logic                  laneValid,
   input  logic                  laneReady,
   input  logic                  busLast,
   output vWritePkg::busReqT     laneReq,
   output logic                  done
);

   logic                  pingState;
   logic                  nextPing;
   logic [`VW_ADDR_W-1:0] rawAddr;
   logic [`VW_ADDR_W-1:0] wrAddr;
   logic                  wrEn;
   logic                  writeDone;
   logic                  burstDone;
   logic [`VW_ADDR_W-1:0] readStart;
   logic                  genValid;
   logic                  genReady;
   logic [`VW_ADDR_W-1:0] genAddr;
   logic                  mValid;
   logic [`VW_DATA_W-1:0] mData;
   logic                  memEn;
   logic [`VW_ADDR_W-1:0] memAddr;
   logic [`VW_DATA_W-1:0] memData;

   assign nextPing = cfg.pingPong ? ~pingState : 1'b0;

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         pingState <= 1'b0;
      else if (run)
         pingState <= nextPing;
   end

   // reads drain the half written during the previous run
   always_comb begin
      readStart = '0;
      readStart[`VW_ADDR_W-1] = cfg.pingPong & ~nextPing;
   end

   // reversal skips the half bit in ping-pong mode
   always_comb begin
      wrAddr = rawAddr;
      if (cfg.wr.reverse) begin
         if (cfg.pingPong) begin
            for (int b = 0; b < `VW_ADDR_W - 1; b++)
               wrAddr[b] = rawAddr[`VW_ADDR_W-2-b];
         end else begin
            for (int b = 0; b < `VW_ADDR_W; b++)
               wrAddr[b] = rawAddr[`VW_ADDR_W-1-b];
         end
      end
      if (cfg.pingPong)
         wrAddr[`VW_ADDR_W-1] = pingState;
   end

   addrGenNested writeGen_i (
      .clk     (clk),
      .rst     (rst),
      .run     (run),
      .cfg     (cfg.wr),
      .addr    (rawAddr),
      .writeEn (wrEn),
      .done    (writeDone)
   );

   addrGenSimple readGen_i (
      .clk    (clk),
      .rst    (rst),
      .run    (run),
      .start  (readStart),
      .incr   (cfg.rd.incrA),
      .period (cfg.rd.perA),
      .count  (cfg.rd.length),
      .valid  (genValid),
      .ready  (genReady),
      .addr   (genAddr)
   );

   memReader reader_i (
      .clk     (clk),
      .rst     (rst),
      .sValid  (genValid),
      .sReady  (genReady),
      .sAddr   (genAddr),
      .mValid  (mValid),
      .mReady  (laneReady),
      .mData   (mData),
      .memEn   (memEn),
      .memAddr (memAddr),
      .memData (memData)
   );

   bufferMem buffer_i (
      .clk       (clk),
      .writeEn   (wrEn),
      .writeAddr (wrAddr),
      .writeData (inData),
      .readEn    (memEn),
      .readAddr  (memAddr),
      .readData  (memData)
   );

   // burst ends on the accepted last beat
   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         burstDone <= 1'b1;
      else if (run)
         burstDone <= (cfg.rd.length == '0);
      else if (laneValid && laneReady && busLast)
         burstDone <= 1'b1;
   end

   assign laneValid     = mValid & ~burstDone;
   assign done          = writeDone & burstDone;
   assign laneReq.addr  = cfg.rd.extAddr;
   assign laneReq.wdata = mData;
   assign laneReq.len   = cfg.rd.length;

endmodule

`default_nettype wire

// ==== hdl/runSequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vWriteSettings_settings.svh"

module runSequencer (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                cfgWrite,
   input  logic [$clog2(`VW_NUM_LANES)-1:0]    cfgLane,
   input  vWritePkg::laneCfgT                  cfg,
   input  logic                                run,
   input  logic                                laneDone [`VW_NUM_LANES],
   output logic                                laneRun,
   output vWritePkg::laneCfgT                  laneCfg [`VW_NUM_LANES],
   output logic                                done
);

   // one configuration slot per lane
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int k = 0; k < `VW_NUM_LANES; k++)
            laneCfg[k] <= '0;
      end else if (cfgWrite) begin
         laneCfg[cfgLane] <= cfg;
      end
   end

   // all lanes start on the same cycle
   assign laneRun = run;

   always_comb begin
      done = 1'b1;
      for (int k = 0; k < `VW_NUM_LANES; k++)
         done = done & laneDone[k];
   end

endmodule

`default_nettype wire

// ==== hdl/busArbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vWriteSettings_settings.svh"

module busArbiter (
   input  logic              clk,
   input  logic              rst,
   input  logic              laneValid [`VW_NUM_LANES],
   input  vWritePkg::busReqT laneReq [`VW_NUM_LANES],
   output logic              laneReady [`VW_NUM_LANES],
   output logic              busValid,
   input  logic              busReady,
   output vWritePkg::busReqT busReq,
   input  logic              busLast
);

   localparam int IDX_W = $clog2(`VW_NUM_LANES);

   logic             locked;
   logic [IDX_W-1:0] grant;
   logic [IDX_W-1:0] lastGrant;
   logic             found;
   logic [IDX_W-1:0] sel;

   // round robin search starting after the last grant
   always_comb begin
      int idx;
      found = 1'b0;
      sel   = lastGrant;
      for (int k = 1; k <= `VW_NUM_LANES; k++) begin
         idx = (int'(lastGrant) + k) % `VW_NUM_LANES;
         if (!found && laneValid[idx]) begin
            found = 1'b1;
            sel   = IDX_W'(idx);
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         locked    <= 1'b0;
         grant     <= '0;
         lastGrant <= IDX_W'(`VW_NUM_LANES - 1);
      end else if (!locked) begin
         if (found) begin
            locked <= 1'b1;
            grant  <= sel;
         end
      end else if (busValid && busReady && busLast) begin
         locked    <= 1'b0;
         lastGrant <= grant;
      end
   end

   assign busValid = locked & laneValid[grant];
   assign busReq   = laneReq[grant];

   always_comb begin
      for (int k = 0; k < `VW_NUM_LANES; k++)
         laneReady[k] = locked && (grant == IDX_W'(k)) && busReady;
   end

endmodule

`default_nettype wire

// ==== hdl/vWriteCluster.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vWriteSettings_settings.svh"

module vWriteCluster (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               cfgWrite,
   input  logic [$clog2(`VW_NUM_LANES)-1:0]   cfgLane,
   input  vWritePkg::laneCfgT                 cfg,
   input  logic                               run,
   output logic                               done,
   input  logic [`VW_DATA_W-1:0]              inData [`VW_NUM_LANES],
   output logic                               busValid,
   input  logic                               busReady,
   output vWritePkg::busReqT                  busReq,
   input  logic                               busLast
);

   logic               laneRun;
   vWritePkg::laneCfgT laneCfg [`VW_NUM_LANES];
   logic               laneDone [`VW_NUM_LANES];
   logic               laneValid [`VW_NUM_LANES];
   logic               laneReady [`VW_NUM_LANES];
   vWritePkg::busReqT  laneReq [`VW_NUM_LANES];

   runSequencer sequencer_i (
      .clk      (clk),
      .rst      (rst),
      .cfgWrite (cfgWrite),
      .cfgLane  (cfgLane),
      .cfg      (cfg),
      .run      (run),
      .laneDone (laneDone),
      .laneRun  (laneRun),
      .laneCfg  (laneCfg),
      .done     (done)
   );

   for (genvar g = 0; g < `VW_NUM_LANES; g++) begin : genLane
      vWriteLane lane_i (
         .clk       (clk),
         .rst       (rst),
         .run       (laneRun),
         .cfg       (laneCfg[g]),
         .inData    (inData[g]),
         .laneValid (laneValid[g]),
         .laneReady (laneReady[g]),
         .busLast   (busLast),
         .laneReq   (laneReq[g]),
         .done      (laneDone[g])
      );
   end

   busArbiter arbiter_i (
      .clk       (clk),
      .rst       (rst),
      .laneValid (laneValid),
      .laneReq   (laneReq),
      .laneReady (laneReady),
      .busValid  (busValid),
      .busReady  (busReady),
      .busReq    (busReq),
      .busLast   (busLast)
   );

endmodule

`default_nettype wire

// ==== bench/tbVWriteCluster.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vWriteSettings_settings.svh"

module tbVWriteCluster;

   localparam int NUM_LANES = `VW_NUM_LANES;
   localparam int NUM_RUNS = 3;
   localparam int AW = `VW_ADDR_W;
   localparam int PW = `VW_PERIOD_W;
   localparam int LW = `VW_LEN_W;
   localparam int LANE_W = $clog2(NUM_LANES);

   logic                  clk = 1'b0;
   logic                  rst = 1'b1;
   logic                  cfgWrite = 1'b0;
   logic [LANE_W-1:0]     cfgLane = '0;
   vWritePkg::laneCfgT    cfg = '0;
   logic                  run = 1'b0;
   logic                  done;
   logic [`VW_DATA_W-1:0] inData [NUM_LANES] = '{default: '0};
   logic                  busValid;
   logic                  busReady = 1'b0;
   vWritePkg::busReqT     busReq;
   logic                  busLast = 1'b0;

   vWritePkg::laneCfgT    laneCfgs [NUM_LANES];
   logic [31:0]           stimSeed = 32'h47091a99;
   int                    cycleCount = 0;
   int                    cycleLimit = 100000;

   // reference model state
   logic [`VW_DATA_W-1:0] modelMem [NUM_LANES][2**AW];
   bit                    modelWritten [NUM_LANES][2**AW];
   logic [`VW_DATA_W-1:0] expData [NUM_LANES][2**LW];
   bit                    expKnown [NUM_LANES][2**LW];
   bit                    modelPing [NUM_LANES];
   bit                    wrBusy [NUM_LANES];
   bit                    burstSeen [NUM_LANES];
   bit                    burstDone [NUM_LANES];
   int                    modelT = 0;
   bit                    runActive = 1'b0;
   bit                    afterRun = 1'b0;

   // bus slave and monitor state
   bit                    inBurst = 1'b0;
   int                    curLane = 0;
   int                    beatIdx = 0;
   int                    checkedBeats = 0;
   bit                    holdCheck = 1'b0;
   vWritePkg::busReqT     heldReq;

   vWriteCluster vWriteCluster_i (
      .clk      (clk),
      .rst      (rst),
      .cfgWrite (cfgWrite),
      .cfgLane  (cfgLane),
      .cfg      (cfg),
      .run      (run),
      .done     (done),
      .inData   (inData),
      .busValid (busValid),
      .busReady (busReady),
      .busReq   (busReq),
      .busLast  (busLast)
   );

   always #2 clk = ~clk;

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("Verification failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic reportMismatch(input string testName, input logic [63:0] expVal,
                                 input logic [63:0] actVal);
      abortRun($sformatf("MISMATCH %s expected %0h actual %0h", testName, expVal, actVal));
   endtask

   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // args: extAddr perA incrA length iter per duty shift incr delay iter2 incr2 reverse
   function automatic vWritePkg::laneCfgT makeCfg(input logic [31:0] extAddr,
         input int perA, input int incrA, input int length, input int iter, input int per,
         input int duty, input int shift, input int incr, input int delay, input int iter2,
         input int incr2, input logic reverse);
      vWritePkg::laneCfgT c;
      c = '0;
      c.pingPong   = 1'b1;
      c.rd.extAddr = extAddr;
      c.rd.perA    = PW'(perA);
      c.rd.incrA   = AW'(incrA);
      c.rd.length  = LW'(length);
      c.wr.iter    = AW'(iter);
      c.wr.per     = PW'(per);
      c.wr.duty    = PW'(duty);
      c.wr.start   = '0;
      c.wr.shift   = AW'(shift);
      c.wr.incr    = AW'(incr);
      c.wr.delay   = PW'(delay);
      c.wr.iter2   = AW'(iter2);
      c.wr.incr2   = AW'(incr2);
      c.wr.reverse = reverse;
      return c;
   endfunction

   function automatic int writeCycles(input vWritePkg::writeCfgT w);
      return int'(w.delay) + int'(w.iter2) * int'(w.iter) * int'(w.per);
   endfunction

   function automatic int longestRun();
      int m;
      int t;
      m = 0;
      for (int k = 0; k < NUM_LANES; k++) begin
         t = writeCycles(laneCfgs[k].wr) + 4 * int'(laneCfgs[k].rd.length) + 20;
         if (t > m)
            m = t;
      end
      return m;
   endfunction

   function automatic logic [AW-1:0] reverseLow(input logic [AW-1:0] v, input int n);
      logic [AW-1:0] r;
      r = v;
      for (int b = 0; b < n; b++)
         r[b] = v[n-1-b];
      return r;
   endfunction

   // reversal first, then the half bit on top
   function automatic logic [AW-1:0] placeWriteAddr(input int k, input logic [AW-1:0] raw);
      logic [AW-1:0] a;
      a = raw;
      if (laneCfgs[k].wr.reverse)
         a = reverseLow(raw, laneCfgs[k].pingPong ? AW - 1 : AW);
      if (laneCfgs[k].pingPong)
         a[AW-1] = modelPing[k];
      return a;
   endfunction

   function automatic bit allFinished();
      bit ok;
      ok = 1'b1;
      for (int k = 0; k < NUM_LANES; k++)
         ok = ok && !wrBusy[k] && burstDone[k];
      return ok;
   endfunction

   task automatic startModelRun();
      logic [AW-1:0] readStart;
      logic [AW-1:0] a;
      for (int k = 0; k < NUM_LANES; k++) begin
         modelPing[k] = laneCfgs[k].pingPong ? !modelPing[k] : 1'b0;
         readStart = '0;
         readStart[AW-1] = laneCfgs[k].pingPong && !modelPing[k];
         // snapshot of the half this run drains
         for (int b = 0; b < int'(laneCfgs[k].rd.length); b++) begin
            a = AW'(int'(readStart) + b * int'(laneCfgs[k].rd.incrA));
            expData[k][b]  = modelMem[k][a];
            expKnown[k][b] = modelWritten[k][a];
         end
         wrBusy[k]    = writeCycles(laneCfgs[k].wr) > 0;
         burstSeen[k] = 1'b0;
         burstDone[k] = laneCfgs[k].rd.length == '0;
      end
      modelT    = 0;
      runActive = 1'b1;
      afterRun  = 1'b1;
   endtask

   task automatic stepWriteModel(input int k);
      vWritePkg::writeCfgT w;
      int c;
      int p;
      int i;
      int j;
      int ii;
      logic [AW-1:0] raw;
      logic [AW-1:0] a;
      w = laneCfgs[k].wr;
      if (modelT >= int'(w.delay)) begin
         c  = modelT - int'(w.delay);
         p  = c % int'(w.per);
         i  = c / int'(w.per);
         j  = i / int'(w.iter);
         ii = i % int'(w.iter);
         if (j < int'(w.iter2) && p < int'(w.duty)) begin
            raw = AW'(int'(w.start) + j * int'(w.incr2) + ii * int'(w.shift)
                      + p * int'(w.incr));
            a = placeWriteAddr(k, raw);
            modelMem[k][a]     = inData[k];
            modelWritten[k][a] = 1'b1;
         end
      end
      if (modelT + 1 >= writeCycles(w))
         wrBusy[k] = 1'b0;
   endtask

   task automatic checkDone();
      if (runActive) begin
         if (afterRun) begin
            assert (!done) else abortRun("done did not fall in the cycle after run");
            afterRun = 1'b0;
         end else if (done) begin
            assert (allFinished())
               else abortRun("done rose before every lane finished its writes and burst");
            runActive = 1'b0;
         end
      end
   endtask

   task automatic watchBus();
      int laneIdx;
      laneIdx = -1;
      if (holdCheck) begin
         assert (busValid) else abortRun("busValid dropped while a stalled beat was waiting");
         assert (busReq.wdata === heldReq.wdata)
            else reportMismatch("stalled beat data", heldReq.wdata, busReq.wdata);
         assert (busReq.addr === heldReq.addr)
            else reportMismatch("stalled beat address", heldReq.addr, busReq.addr);
         holdCheck = 1'b0;
      end
      if (busValid && !busReady) begin
         holdCheck = 1'b1;
         heldReq   = busReq;
      end
      if (busValid && busReady) begin
         if (!inBurst) begin
            for (int k = 0; k < NUM_LANES; k++) begin
               if (laneCfgs[k].rd.extAddr == busReq.addr)
                  laneIdx = k;
            end
            assert (laneIdx >= 0) else abortRun("burst address belongs to no lane");
            assert (runActive) else abortRun("a burst started outside of a run");
            assert (!burstSeen[laneIdx]) else abortRun("a lane sent two bursts in one run");
            curLane            = laneIdx;
            beatIdx            = 0;
            inBurst            = 1'b1;
            burstSeen[laneIdx] = 1'b1;
         end
         // any other lane's beat here means interleaving
         assert (busReq.addr == laneCfgs[curLane].rd.extAddr)
            else reportMismatch($sformatf("lane %0d burst address", curLane),
                                laneCfgs[curLane].rd.extAddr, busReq.addr);
         assert (busReq.len == laneCfgs[curLane].rd.length)
            else reportMismatch($sformatf("lane %0d burst length", curLane),
                                laneCfgs[curLane].rd.length, busReq.len);
         if (expKnown[curLane][beatIdx]) begin
            assert (busReq.wdata === expData[curLane][beatIdx])
               else reportMismatch($sformatf("lane %0d beat %0d data", curLane, beatIdx),
                                   expData[curLane][beatIdx], busReq.wdata);
            checkedBeats++;
         end
         if (busLast) begin
            inBurst            = 1'b0;
            burstDone[curLane] = 1'b1;
            beatIdx            = 0;
         end else begin
            beatIdx++;
         end
      end
   endtask

   always @(posedge clk) begin
      if (!rst) begin
         checkDone();
         watchBus();
         if (run) begin
            startModelRun();
         end else begin
            for (int k = 0; k < NUM_LANES; k++) begin
               if (wrBusy[k])
                  stepWriteModel(k);
            end
            modelT++;
         end
      end
   end

   // input stream, random ready and the slave's last flag
   always @(negedge clk) begin
      for (int k = 0; k < NUM_LANES; k++) begin
         stimSeed  = lcgNext(stimSeed);
         inData[k] = stimSeed;
      end
      stimSeed = lcgNext(stimSeed);
      busReady = stimSeed[31:30] != 2'b00;
      busLast  = beatIdx == int'(busReq.len) - 1;
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount > cycleLimit)
         abortRun($sformatf("timeout after %0d cycles without the runs completing",
                            cycleCount));
   end

   initial begin
      int expectedBeats;
      laneCfgs[0] = makeCfg(32'h1000_0000, 1, 1, 16, 4, 4, 4, 4, 1, 0, 1, 0, 1'b0);
      laneCfgs[1] = makeCfg(32'h2000_0040, 2, 1, 24, 4, 5, 3, 3, 1, 7, 2, 12, 1'b0);
      laneCfgs[2] = makeCfg(32'h3000_0100, 1, 32, 16, 2, 8, 8, 8, 1, 0, 1, 0, 1'b1);
      laneCfgs[3] = makeCfg(32'h4000_0200, 3, 1, 12, 3, 6, 2, 2, 1, 3, 2, 6, 1'b0);
      cycleLimit = NUM_RUNS * NUM_LANES * longestRun() + 8 + 2 * NUM_LANES + 32;
      expectedBeats = 0;
      for (int k = 0; k < NUM_LANES; k++)
         expectedBeats += (NUM_RUNS - 1) * int'(laneCfgs[k].rd.length);

      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      assert (done) else abortRun("done is low after reset");

      for (int k = 0; k < NUM_LANES; k++) begin
         cfgWrite = 1'b1;
         cfgLane  = LANE_W'(k);
         cfg      = laneCfgs[k];
         @(negedge clk);
      end
      cfgWrite = 1'b0;

      // first run drains a half that was never written
      for (int r = 0; r < NUM_RUNS; r++) begin
         @(negedge clk);
         run = 1'b1;
         @(negedge clk);
         run = 1'b0;
         while (runActive)
            @(negedge clk);
      end

      repeat (4) @(negedge clk);
      if (checkedBeats != expectedBeats) begin
         reportMismatch("compared data beats", expectedBeats, checkedBeats);
      end else begin
         $display("Verification passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== vWriteCluster.f ====
+incdir+common
common/vWritePkg.sv
hdl/addrGenNested.sv
hdl/addrGenSimple.sv
hdl/bufferMem.sv
hdl/memReader.sv
vWriteLane/vWriteLane.sv
hdl/runSequencer.sv
hdl/busArbiter.sv
hdl/vWriteCluster.sv
bench/tbVWriteCluster.sv

// ==== Bender.yml ====
package:
  name: vWriteCluster

sources:
  - include_dirs:
      - common
    files:
      - common/vWritePkg.sv
      - hdl/addrGenNested.sv
      - hdl/addrGenSimple.sv
      - hdl/bufferMem.sv
      - hdl/memReader.sv
      - vWriteLane/vWriteLane.sv
      - hdl/runSequencer.sv
      - hdl/busArbiter.sv
      - hdl/vWriteCluster.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tbVWriteCluster.sv
